// File: tests/pio_cases.txt
# wb wt ssb sso out_base out_cnt set_base set_cnt in_base side_base jmp_pin dir
# input_pins exp_pins exp_dirs rd_delay n_prog n_tx n_rx, then program, TX and RX words
6
0 4 0 0 0 20 0 5 0 0 0 1 00000000 00000000 00000000 0 5 4 4
80A0 6020 A051 4040 8020
12345678 00000001 F0000000 0000FFFF
1E6A2C48 80000000 0000000F FFFF0000
0 4 0 0 0 20 0 5 0 0 0 1 00000000 00000000 00000000 0 5 0 1
E025 4061 0041 8020 0004
00000000
0 2 2 1 0 20 4 3 0 A 0 1 00000000 00000450 00000070 0 3 0 0
E387 F805 0002
0 3 0 0 0 20 0 5 4 0 0 0 0000A5C8 00000000 00000000 0 4 0 1
20A3 4008 8020 0003
0000005C
2 4 0 0 0 20 0 5 0 0 0 1 00000000 00000000 00000000 0 8 0 4
0000 0001 4020 8020 0046 E03F E023 0002
00000000 FFFFFFFF 00000003 00000003
0 4 0 0 0 20 0 5 0 0 0 1 00000000 00000000 00000000 3C 5 0 6
E025 4020 8020 0041 0004
00000005 00000004 00000003 00000002 00000001 00000000

// File: all.f
hdl/pio_pkg.sv
hdl/pio_instr_if.sv
hdl/pio_decoder.sv
hdl/pio_clock_div.sv
hdl/pio_pc.sv
hdl/pio_scratch.sv
hdl/pio_shifter.sv
hdl/pio_fifo.sv
hdl/pio_machine.sv
hdl/pio_top.sv
tests/pio_top_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pio_top_tb
FILELIST = all.f

BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
SRCS  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD)

// File: tests/pio_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pio_top_tb import pio_pkg::*; ;

  logic                   clk;
  logic                   reset;
  logic                   en;
  logic [PIO_DIV_W-1:0]   div;
  logic                   imem_write;
  logic [PIO_ADDR_W-1:0]  imem_addr;
  logic [PIO_INSTR_W-1:0] imem_data;
  logic [PIO_ADDR_W-1:0]  wrap_bottom;
  logic [PIO_ADDR_W-1:0]  wrap_top;
  logic [2:0]             sideset_bits;
  logic                   sideset_opt;
  logic [4:0]             pins_out_base;
  logic [5:0]             pins_out_count;
  logic [4:0]             pins_set_base;
  logic [2:0]             pins_set_count;
  logic [4:0]             pins_in_base;
  logic [4:0]             pins_side_base;
  logic [4:0]             jmp_pin;
  logic                   shift_dir;
  logic [PIO_DATA_W-1:0]  input_pins;
  logic                   tx_write;
  logic [PIO_DATA_W-1:0]  tx_data;
  logic                   tx_full;
  logic                   rx_read;
  logic [PIO_DATA_W-1:0]  rx_data;
  logic                   rx_empty;
  logic [PIO_ADDR_W-1:0]  pc;
  logic [PIO_DATA_W-1:0]  output_pins;
  logic [PIO_DATA_W-1:0]  pin_directions;

  int                     fd;
  int                     status;
  int                     num_cases;
  int                     rx_errors;
  int                     pin_errors;
  int                     state_errors;
  int                     file_errors;
  logic [31:0]            word;
  logic [8*128-1:0]       line;
  logic [31:0]            cfg [19]; // Column order as in the cases file
  logic [PIO_INSTR_W-1:0] prog [PIO_IMEM_DEPTH];
  logic [31:0]            tx_words [$];
  logic [31:0]            rx_words [$];

  pio_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic read_word(output logic [31:0] value);
    status = $fscanf(fd, "%h", value);
    if (status != 1) begin
      file_errors++;
      $display("Could not read a value from tests/pio_cases.txt");
    end
  endtask

  task automatic pulse_reset();
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic load_program(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      imem_write <= 1'b1;
      imem_addr  <= PIO_ADDR_W'(i);
      imem_data  <= prog[i];
    end
    @(posedge clk);
    imem_write <= 1'b0;
  endtask

  task automatic send_tx_words();
    foreach (tx_words[i]) begin
      repeat ($urandom % 4) @(posedge clk); // Gap between writes
      @(posedge clk);
      while (tx_full) @(posedge clk);
      tx_write <= 1'b1;
      tx_data  <= tx_words[i];
      @(posedge clk);
      tx_write <= 1'b0;
    end
  endtask

  task automatic receive_rx_words(input int gap);
    foreach (rx_words[i]) begin
      repeat (gap) @(posedge clk);
      @(negedge clk);
      while (rx_empty) @(negedge clk);
      assert (rx_data == rx_words[i]) else begin
        rx_errors++;
        $display("Error: time %0t rx_data got %h expected %h", $time, rx_data, rx_words[i]);
      end
      @(posedge clk);
      rx_read <= 1'b1;
      @(posedge clk);
      rx_read <= 1'b0;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got == exp) else begin
      state_errors++;
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // State right after reset, before the program is loaded
  task automatic verify_reset_state();
    @(negedge clk);
    compare_value("pc", 32'(pc), cfg[0]);
    compare_value("tx_full", 32'(tx_full), 32'd0);
    compare_value("rx_empty", 32'(rx_empty), 32'd1);
    compare_value("output_pins", output_pins, 32'd0);
    compare_value("pin_directions", pin_directions, 32'd0);
  endtask

  task automatic check_pins();
    assert (output_pins == cfg[13]) else begin
      pin_errors++;
      $display("Error: time %0t output_pins got %h expected %h", $time, output_pins, cfg[13]);
    end
    assert (pin_directions == cfg[14]) else begin
      pin_errors++;
      $display("Error: time %0t pin_directions got %h expected %h",
               $time, pin_directions, cfg[14]);
    end
  endtask

  task automatic run_case();
    @(posedge clk);
    en             <= 1'b0;
    div            <= PIO_DIV_W'(1 + $urandom % 4);
    wrap_bottom    <= cfg[0][4:0];
    wrap_top       <= cfg[1][4:0];
    sideset_bits   <= cfg[2][2:0];
    sideset_opt    <= cfg[3][0];
    pins_out_base  <= cfg[4][4:0];
    pins_out_count <= cfg[5][5:0];
    pins_set_base  <= cfg[6][4:0];
    pins_set_count <= cfg[7][2:0];
    pins_in_base   <= cfg[8][4:0];
    pins_side_base <= cfg[9][4:0];
    jmp_pin        <= cfg[10][4:0];
    shift_dir      <= cfg[11][0];
    input_pins     <= cfg[12];
    pulse_reset();
    verify_reset_state();
    load_program(int'(cfg[16]));
    send_tx_words();
    @(negedge clk);
    compare_value("tx_full", 32'(tx_full), 32'(cfg[17] >= PIO_FIFO_DEPTH)); // Machine idle
    @(posedge clk);
    en <= 1'b1;
    if (cfg[18] == 0) begin
      @(negedge clk);
      while (pc != PIO_ADDR_W'(cfg[16] - 1)) @(negedge clk); // Halt on last word
    end else begin
      receive_rx_words(int'(cfg[15]));
    end
    @(posedge clk);
    en <= 1'b0;
    @(negedge clk);
    check_pins();
  endtask

  initial begin
    reset          = 1'b1;
    en             = 1'b0;
    div            = 16'd1;
    imem_write     = 1'b0;
    imem_addr      = '0;
    imem_data      = '0;
    wrap_bottom    = '0;
    wrap_top       = '1;
    sideset_bits   = '0;
    sideset_opt    = 1'b0;
    pins_out_base  = '0;
    pins_out_count = 6'd32;
    pins_set_base  = '0;
    pins_set_count = 3'd5;
    pins_in_base   = '0;
    pins_side_base = '0;
    jmp_pin        = '0;
    shift_dir      = 1'b1;
    input_pins     = '0;
    tx_write       = 1'b0;
    tx_data        = '0;
    rx_read        = 1'b0;
    rx_errors      = 0;
    pin_errors     = 0;
    state_errors   = 0;
    file_errors    = 0;
    num_cases      = 0;
    void'($urandom(70256));
    fd = $fopen("tests/pio_cases.txt", "r");
    if (fd == 0) begin
      file_errors++;
      $display("Could not open tests/pio_cases.txt");
    end else begin
      status = $fgets(line, fd); // Two comment lines
      status = $fgets(line, fd);
      status = $fscanf(fd, "%d", num_cases);
      if (status != 1) begin
        file_errors++;
        $display("Could not read the number of cases");
        num_cases = 0;
      end
      for (int c = 0; c < num_cases; c++) begin
        tx_words.delete();
        rx_words.delete();
        for (int i = 0; i < 19; i++) read_word(cfg[i]);
        for (int i = 0; i < int'(cfg[16]); i++) begin
          read_word(word);
          prog[i] = word[PIO_INSTR_W-1:0];
        end
        for (int i = 0; i < int'(cfg[17]); i++) begin
          read_word(word);
          tx_words.push_back(word);
        end
        for (int i = 0; i < int'(cfg[18]); i++) begin
          read_word(word);
          rx_words.push_back(word);
        end
        run_case();
      end
      $fclose(fd);
    end
    $display("Errors: %0d rx, %0d pins, %0d state, %0d file",
             rx_errors, pin_errors, state_errors, file_errors);
    if (rx_errors + pin_errors + state_errors + file_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog sized for the slowest divider
  initial begin
    wait (num_cases > 0);
    repeat (num_cases * 2000 * 4) @(posedge clk);
    $display("Timeout: the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/pio_top.sv
`timescale 1ns/10ps
`default_nettype none

module pio_top import pio_pkg::*; (
  input wire                    clk,
  input wire                    reset,
  input wire                    en,
  input wire [PIO_DIV_W-1:0]    div,
  input wire                    imem_write,
  input wire [PIO_ADDR_W-1:0]   imem_addr,
  input wire [PIO_INSTR_W-1:0]  imem_data,
  input wire [PIO_ADDR_W-1:0]   wrap_bottom,
  input wire [PIO_ADDR_W-1:0]   wrap_top,
  input wire [2:0]              sideset_bits,
  input wire                    sideset_opt,
  input wire [4:0]              pins_out_base,
  input wire [5:0]              pins_out_count,
  input wire [4:0]              pins_set_base,
  input wire [2:0]              pins_set_count,
  input wire [4:0]              pins_in_base,
  input wire [4:0]              pins_side_base,
  input wire [4:0]              jmp_pin,
  input wire                    shift_dir,
  input wire [PIO_DATA_W-1:0]   input_pins,
  input wire                    tx_write,
  input wire [PIO_DATA_W-1:0]   tx_data,
  output logic                  tx_full,
  input wire                    rx_read,
  output logic [PIO_DATA_W-1:0] rx_data,
  output logic                  rx_empty,
  output logic [PIO_ADDR_W-1:0] pc,
  output logic [PIO_DATA_W-1:0] output_pins,
  output logic [PIO_DATA_W-1:0] pin_directions
);

  logic [PIO_INSTR_W-1:0] imem [PIO_IMEM_DEPTH];
  logic [PIO_DATA_W-1:0]  tx_head;
  logic [PIO_DATA_W-1:0]  isr_data;
  logic                   tx_empty;
  logic                   rx_full;
  logic                   push;
  logic                   pull;

  always_ff @(posedge clk) begin
    if (imem_write) imem[imem_addr] <= imem_data; // Loaded with en low
  end

  pio_machine u_machine (
    .clk(clk), .reset(reset), .en(en), .div(div), .instr(imem[pc]),
    .input_pins(input_pins), .tx_data(tx_head), .tx_empty(tx_empty), .rx_full(rx_full),
    .wrap_bottom(wrap_bottom), .wrap_top(wrap_top),
    .sideset_bits(sideset_bits), .sideset_opt(sideset_opt),
    .pins_out_base(pins_out_base), .pins_out_count(pins_out_count),
    .pins_set_base(pins_set_base), .pins_set_count(pins_set_count),
    .pins_in_base(pins_in_base), .pins_side_base(pins_side_base),
    .jmp_pin(jmp_pin), .shift_dir(shift_dir),
    .pc(pc), .push(push), .pull(pull), .isr_data(isr_data),
    .output_pins(output_pins), .pin_directions(pin_directions)
  );

  pio_fifo u_tx_fifo (
    .clk(clk), .reset(reset), .write(tx_write), .wdata(tx_data),
    .read(pull), .rdata(tx_head), .full(tx_full), .empty(tx_empty)
  );

  pio_fifo u_rx_fifo (
    .clk(clk), .reset(reset), .write(push), .wdata(isr_data),
    .read(rx_read), .rdata(rx_data), .full(rx_full), .empty(rx_empty)
  );

endmodule

`default_nettype wire

// File: hdl/pio_machine.sv
`timescale 1ns/10ps
`default_nettype none

module pio_machine import pio_pkg::*; (
  input wire                    clk,
  input wire                    reset,
  input wire                    en,
  input wire [PIO_DIV_W-1:0]    div,
  input wire [PIO_INSTR_W-1:0]  instr,
  input wire [PIO_DATA_W-1:0]   input_pins,
  input wire [PIO_DATA_W-1:0]   tx_data,
  input wire                    tx_empty,
  input wire                    rx_full,
  input wire [PIO_ADDR_W-1:0]   wrap_bottom,
  input wire [PIO_ADDR_W-1:0]   wrap_top,
  input wire [2:0]              sideset_bits,
  input wire                    sideset_opt,
  input wire [4:0]              pins_out_base,
  input wire [5:0]              pins_out_count,
  input wire [4:0]              pins_set_base,
  input wire [2:0]              pins_set_count,
  input wire [4:0]              pins_in_base,
  input wire [4:0]              pins_side_base,
  input wire [4:0]              jmp_pin,
  input wire                    shift_dir,
  output logic [PIO_ADDR_W-1:0] pc,
  output logic                  push,
  output logic                  pull,
  output logic [PIO_DATA_W-1:0] isr_data,
  output logic [PIO_DATA_W-1:0] output_pins,
  output logic [PIO_DATA_W-1:0] pin_directions
);

  pio_instr_if instr_if ();

  logic                  penable;
  logic                  tick;
  logic                  stall;
  logic                  waiting;
  logic [4:0]            delay_cnt;
  logic [PIO_DATA_W-1:0] x;
  logic [PIO_DATA_W-1:0] y;
  logic [PIO_DATA_W-1:0] osr;
  logic [PIO_DATA_W-1:0] osr_out;
  logic [PIO_DATA_W-1:0] isr_out;
  logic [5:0]            osr_cnt;
  logic [PIO_DATA_W-1:0] pins_in_rot;
  logic [PIO_DATA_W-1:0] new_val;
  logic [PIO_DATA_W-1:0] in_val;
  logic [PIO_DATA_W-1:0] mov_src;
  logic [PIO_DATA_W-1:0] pins_next;
  logic [PIO_DATA_W-1:0] dirs_next;
  logic [5:0]            side_cnt;
  logic jmp, set_x, set_y, dec_x, dec_y, in_shift, out_shift, push_op, pull_op;
  logic set_pins, set_dirs, out_pins, out_dirs;

  // Places val into cur at base, count bits wide, wrapping at 32
  function automatic logic [PIO_DATA_W-1:0] write_field(
    input logic [PIO_DATA_W-1:0] cur,
    input logic [PIO_DATA_W-1:0] val,
    input logic [4:0]            base,
    input logic [5:0]            cnt
  );
    logic [PIO_DATA_W-1:0] mask;
    logic [PIO_DATA_W-1:0] mask_rot;
    logic [PIO_DATA_W-1:0] val_rot;
    mask     = ~({PIO_DATA_W{1'b1}} << cnt);
    mask_rot = (mask << base) | (mask >> (6'd32 - base));
    val_rot  = (val << base) | (val >> (6'd32 - base));
    return (cur & ~mask_rot) | (val_rot & mask_rot);
  endfunction

  assign tick        = en && penable;
  assign stall       = (delay_cnt != 5'd0) || waiting;
  assign push        = tick && !stall && push_op;
  assign pull        = tick && !stall && pull_op;
  assign isr_data    = isr_out;
  assign pins_in_rot = (input_pins >> pins_in_base) | (input_pins << (6'd32 - pins_in_base));
  assign side_cnt    = 6'(sideset_bits) - 6'(sideset_opt && sideset_bits != 3'd0);

  always_comb begin
    {jmp, set_x, set_y, dec_x, dec_y, in_shift, out_shift, push_op, pull_op} = '0;
    {set_pins, set_dirs, out_pins, out_dirs} = '0;
    waiting = 1'b0;
    new_val = '0;
    in_val  = '0; // Also clears the ISR on PUSH
    mov_src = '0;
    case (instr_if.op)
      OP_JMP: begin
        new_val = 32'(instr_if.op2);
        case (pio_jmp_cond_e'(instr_if.op1))
          COND_ALWAYS: jmp = 1'b1;
          COND_X_ZERO: jmp = x == '0;
          COND_X_DEC: begin
            jmp   = x != '0;
            dec_x = 1'b1;
          end
          COND_Y_ZERO: jmp = y == '0;
          COND_Y_DEC: begin
            jmp   = y != '0;
            dec_y = 1'b1;
          end
          COND_X_NE_Y: jmp = x != y;
          COND_PIN:    jmp = input_pins[jmp_pin];
          COND_OSR_NE: jmp = osr_cnt < 6'd32;
        endcase
      end
      OP_WAIT: waiting = input_pins[instr_if.op2] != instr_if.op1[2];
      OP_IN: begin
        in_shift = 1'b1;
        case (pio_src_e'(instr_if.op1))
          SRC_PINS: in_val = pins_in_rot;
          SRC_X:    in_val = x;
          SRC_Y:    in_val = y;
          default:  in_val = '0;
        endcase
      end
      OP_OUT: begin
        out_shift = 1'b1;
        new_val   = osr_out;
        case (pio_dest_e'(instr_if.op1))
          DEST_PINS:    out_pins = 1'b1;
          DEST_X:       set_x = 1'b1;
          DEST_Y:       set_y = 1'b1;
          DEST_PINDIRS: out_dirs = 1'b1;
          DEST_PC:      jmp = 1'b1;
          default:      ;
        endcase
      end
      OP_PUSHPULL: begin
        if (instr_if.op1[2]) begin
          pull_op = 1'b1;
          waiting = tx_empty;
        end else begin
          push_op = 1'b1;
          waiting = rx_full;
        end
      end
      OP_MOV: begin
        case (pio_src_e'(instr_if.op2[2:0]))
          SRC_PINS: mov_src = pins_in_rot;
          SRC_X:    mov_src = x;
          SRC_Y:    mov_src = y;
          default:  mov_src = '0;
        endcase
        case (instr_if.op2[4:3])
          2'd1:    new_val = ~mov_src;
          2'd2:    new_val = {<<{mov_src}}; // Bit reverse
          default: new_val = mov_src;
        endcase
        case (pio_dest_e'(instr_if.op1))
          DEST_X:  set_x = 1'b1;
          DEST_Y:  set_y = 1'b1;
          DEST_PC: jmp = 1'b1;
          default: ;
        endcase
      end
      OP_SET: begin
        new_val = 32'(instr_if.op2);
        case (pio_dest_e'(instr_if.op1))
          DEST_PINS:    set_pins = 1'b1;
          DEST_X:       set_x = 1'b1;
          DEST_Y:       set_y = 1'b1;
          DEST_PINDIRS: set_dirs = 1'b1;
          default:      ;
        endcase
      end
      default: ; // IRQ
    endcase
  end

  always_comb begin
    pins_next = output_pins;
    dirs_next = pin_directions;
    if (set_pins) pins_next = write_field(pins_next, new_val, pins_set_base, 6'(pins_set_count));
    if (set_dirs) dirs_next = write_field(dirs_next, new_val, pins_set_base, 6'(pins_set_count));
    if (out_pins) pins_next = write_field(pins_next, new_val, pins_out_base, pins_out_count);
    if (out_dirs) dirs_next = write_field(dirs_next, new_val, pins_out_base, pins_out_count);
    if (instr_if.side_en) begin // Side-set wins over SET and OUT
      pins_next = write_field(pins_next, 32'(instr_if.side_set), pins_side_base, side_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt      <= '0;
      output_pins    <= '0;
      pin_directions <= '0;
    end else if (tick) begin
      if (delay_cnt != 5'd0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else begin
        if (!waiting) delay_cnt <= instr_if.delay;
        output_pins    <= pins_next;
        pin_directions <= dirs_next;
      end
    end
  end

  assign osr = pull_op ? tx_data : '0; // Zeros shift in behind OUT

  pio_decoder u_decoder (
    .instr(instr), .sideset_bits(sideset_bits), .sideset_opt(sideset_opt), .dec(instr_if)
  );

  pio_clock_div u_clock_div (.clk(clk), .reset(reset), .div(div), .penable(penable));

  pio_pc u_pc (
    .clk(clk), .reset(reset), .tick(tick), .stalled(stall), .jmp(jmp),
    .target(new_val[PIO_ADDR_W-1:0]), .wrap_bottom(wrap_bottom), .wrap_top(wrap_top), .pc(pc)
  );

  pio_scratch u_x (
    .clk(clk), .reset(reset), .tick(tick), .stalled(stall),
    .din(new_val), .set(set_x), .dec(dec_x), .dout(x)
  );

  pio_scratch u_y (
    .clk(clk), .reset(reset), .tick(tick), .stalled(stall),
    .din(new_val), .set(set_y), .dec(dec_y), .dout(y)
  );

  pio_shifter #(.RESET_CNT(6'd0)) u_isr (
    .clk(clk), .reset(reset), .tick(tick), .stalled(stall), .dir(shift_dir),
    .count(instr_if.op2), .do_shift(in_shift), .load(push_op), .din(in_val),
    .dout(isr_out), .shifted(), .shift_cnt()
  );

  pio_shifter #(.RESET_CNT(6'd32)) u_osr (
    .clk(clk), .reset(reset), .tick(tick), .stalled(stall), .dir(shift_dir),
    .count(instr_if.op2), .do_shift(out_shift), .load(pull_op), .din(osr),
    .dout(), .shifted(osr_out), .shift_cnt(osr_cnt)
  );

endmodule

`default_nettype wire

// File: hdl/pio_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module pio_fifo import pio_pkg::*; (
  input wire                    clk,
  input wire                    reset,
  input wire                    write,
  input wire [PIO_DATA_W-1:0]   wdata,
  input wire                    read,
  output logic [PIO_DATA_W-1:0] rdata,
  output logic                  full,
  output logic                  empty
);

  logic [PIO_DATA_W-1:0]     mem [PIO_FIFO_DEPTH];
  logic [PIO_FIFO_PTR_W-1:0] wr_ptr;
  logic [PIO_FIFO_PTR_W-1:0] rd_ptr;
  logic [PIO_FIFO_PTR_W:0]   count;
  logic                      do_write;
  logic                      do_read;

  assign full     = count == (PIO_FIFO_PTR_W + 1)'(PIO_FIFO_DEPTH);
  assign empty    = count == '0;
  assign do_write = write && !full;
  assign do_read  = read && !empty;
  assign rdata    = mem[rd_ptr]; // Head

  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PIO_FIFO_PTR_W + 1)'(do_write) - (PIO_FIFO_PTR_W + 1)'(do_read);
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    (full && !read) |=> full);
  a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
    (empty && !write) |=> empty);

endmodule

`default_nettype wire

// File: hdl/pio_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module pio_shifter import pio_pkg::*; #(
  parameter logic [5:0] RESET_CNT = 6'd0 // 32 for the OSR
) (
  input wire                    clk,
  input wire                    reset,
  input wire                    tick,
  input wire                    stalled,
  input wire                    dir, // 1 shifts right
  input wire [4:0]              count,
  input wire                    do_shift,
  input wire                    load,
  input wire [PIO_DATA_W-1:0]   din,
  output logic [PIO_DATA_W-1:0] dout,
  output logic [PIO_DATA_W-1:0] shifted,
  output logic [5:0]            shift_cnt
);

  logic [5:0]            n;
  logic [6:0]            cnt_sum;
  logic [PIO_DATA_W-1:0] mask;

  assign n       = (count == 5'd0) ? 6'd32 : {1'b0, count};
  assign mask    = ~({PIO_DATA_W{1'b1}} << n);
  assign cnt_sum = {1'b0, shift_cnt} + {1'b0, n};
  assign shifted = dir ? (dout & mask) : (dout >> (6'd32 - n)); // Right-aligned

  always_ff @(posedge clk) begin
    if (reset) begin
      dout      <= '0;
      shift_cnt <= RESET_CNT;
    end else if (tick && !stalled) begin
      if (load) begin
        dout      <= din;
        shift_cnt <= '0;
      end else if (do_shift) begin
        if (dir) dout <= (dout >> n) | (din << (6'd32 - n));
        else dout <= (dout << n) | (din & mask);
        shift_cnt <= (cnt_sum > 7'd32) ? 6'd32 : cnt_sum[5:0]; // Saturate
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/pio_scratch.sv
`timescale 1ns/10ps
`default_nettype none

module pio_scratch import pio_pkg::*; (
  input wire                    clk,
  input wire                    reset,
  input wire                    tick,
  input wire                    stalled,
  input wire [PIO_DATA_W-1:0]   din,
  input wire                    set,
  input wire                    dec, // Post-decrement from JMP
  output logic [PIO_DATA_W-1:0] dout
);

  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else if (tick && !stalled) begin
      if (set) dout <= din;
      else if (dec) dout <= dout - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pio_pc.sv
`timescale 1ns/10ps
`default_nettype none

module pio_pc import pio_pkg::*; (
  input wire                   clk,
  input wire                   reset,
  input wire                   tick,
  input wire                   stalled,
  input wire                   jmp,
  input wire [PIO_ADDR_W-1:0]  target,
  input wire [PIO_ADDR_W-1:0]  wrap_bottom,
  input wire [PIO_ADDR_W-1:0]  wrap_top,
  output logic [PIO_ADDR_W-1:0] pc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= wrap_bottom;
    end else if (tick && !stalled) begin
      if (jmp) pc <= target;
      else if (pc == wrap_top) pc <= wrap_bottom; // Program wrap
      else pc <= pc + 1'b1;
    end
  end

  a_pc_needs_tick: assert property (@(posedge clk) disable iff (reset)
    !tick |=> $stable(pc));

endmodule

`default_nettype wire

// File: hdl/pio_clock_div.sv
`timescale 1ns/10ps
`default_nettype none

module pio_clock_div import pio_pkg::*; (
  input wire                 clk,
  input wire                 reset,
  input wire [PIO_DIV_W-1:0] div,
  output logic               penable
);

  logic [PIO_DIV_W-1:0] count;

  assign penable = count <= PIO_DIV_W'(1); // Reload cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (penable) begin
      count <= div;
    end else begin
      count <= count - 1'b1;
    end
  end

  a_penable_pulse: assert property (@(posedge clk) disable iff (reset)
    (penable && div > PIO_DIV_W'(1)) |=> !penable);

endmodule

`default_nettype wire

// File: hdl/pio_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module pio_decoder import pio_pkg::*; (
  input wire [PIO_INSTR_W-1:0] instr,
  input wire [2:0]             sideset_bits, // Includes the enable bit
  input wire                   sideset_opt,
  pio_instr_if.producer        dec
);

  logic [4:0] field;
  logic [4:0] side_raw;
  logic [4:0] side_mask;

  assign field     = instr[12:8];
  assign side_raw  = field >> (3'd5 - sideset_bits);
  assign side_mask = 5'h1f >> (3'd6 - sideset_bits); // Drops the enable bit

  always_comb begin
    dec.op    = pio_opcode_e'(instr[15:13]);
    dec.op1   = instr[7:5];
    dec.op2   = instr[4:0];
    dec.delay = field & (5'h1f >> sideset_bits);
    if (sideset_opt && sideset_bits != 3'd0) begin
      dec.side_en  = field[4];
      dec.side_set = side_raw & side_mask;
    end else begin
      dec.side_en  = sideset_bits != 3'd0;
      dec.side_set = side_raw;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pio_instr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pio_instr_if import pio_pkg::*; ();

  pio_opcode_e op;
  logic [2:0]  op1;
  logic [4:0]  op2;
  logic [4:0]  delay;
  logic [4:0]  side_set; // Right-aligned side-set value
  logic        side_en;

  modport producer (output op, op1, op2, delay, side_set, side_en);
  modport consumer (input op, op1, op2, delay, side_set, side_en);

endinterface

`default_nettype wire

// File: hdl/pio_pkg.sv
`default_nettype none

package pio_pkg;

  localparam int PIO_DATA_W     = 32;
  localparam int PIO_ADDR_W     = 5;
  localparam int PIO_INSTR_W    = 16;
  localparam int PIO_FIFO_DEPTH = 4;
  localparam int PIO_FIFO_PTR_W = $clog2(PIO_FIFO_DEPTH);
  localparam int PIO_DIV_W      = 16;
  localparam int PIO_IMEM_DEPTH = 1 << PIO_ADDR_W;

  typedef enum logic [2:0] {
    OP_JMP, OP_WAIT, OP_IN, OP_OUT, OP_PUSHPULL, OP_MOV, OP_IRQ, OP_SET
  } pio_opcode_e;

  typedef enum logic [2:0] {
    COND_ALWAYS, // Unconditional
    COND_X_ZERO,
    COND_X_DEC, // X nonzero, then X--
    COND_Y_ZERO,
    COND_Y_DEC, // Y nonzero, then Y--
    COND_X_NE_Y,
    COND_PIN,
    COND_OSR_NE // OSR not empty
  } pio_jmp_cond_e;

  typedef enum logic [2:0] {
    DEST_PINS = 3'd0, DEST_X = 3'd1, DEST_Y = 3'd2, DEST_NULL = 3'd3,
    DEST_PINDIRS = 3'd4, DEST_PC = 3'd5
  } pio_dest_e;

  typedef enum logic [2:0] {
    SRC_PINS = 3'd0, SRC_X = 3'd1, SRC_Y = 3'd2, SRC_NULL = 3'd3
  } pio_src_e;

endpackage

`default_nettype wire
